/* hw/gpu_pkg.sv */
package gpu_pkg;

    localparam int NUM_THREADS   = 4;
    localparam int NUM_WARPS     = 4;
    localparam int NW_BITS       = 2;
    localparam int NB_BITS       = 2;
    localparam int NUM_TEX       = 2;
    localparam int TEX_ADDR_BITS = 9;

    typedef enum logic [2:0] {
        GPU_TMC    = 3'd0,
        GPU_WSPAWN = 3'd1,
        GPU_SPLIT  = 3'd2,
        GPU_BAR    = 3'd3,
        GPU_TEX    = 3'd4
    } gpu_op_e;

    typedef struct packed {
        gpu_op_e                      op_type;
        logic                         op_mod;
        logic [NW_BITS-1:0]           wid;
        logic [NUM_THREADS-1:0]       tmask;
        logic [31:0]                  pc;
        logic [31:0]                  next_pc;
        logic [NUM_THREADS-1:0][31:0] rs1_data;
        logic [NUM_THREADS-1:0][31:0] rs2_data;
    } gpu_req_t;

    typedef struct packed {
        logic                   valid;
        logic [NUM_THREADS-1:0] tmask;
    } tmc_t;

    typedef struct packed {
        logic                 valid;
        logic [NUM_WARPS-1:0] wmask;
        logic [31:0]          pc;
    } wspawn_t;

    typedef struct packed {
        logic               valid;
        logic [NB_BITS-1:0] id;
        logic [NW_BITS-1:0] size_m1;
    } barrier_t;

    typedef struct packed {
        logic                   valid;
        logic                   diverged;
        logic [NUM_THREADS-1:0] then_mask;
        logic [NUM_THREADS-1:0] else_mask;
        logic [31:0]            pc;
    } split_t;

    // control fields fill the low bits of a full texel word
    localparam int CTL_PAD_BITS = NUM_THREADS * 32
        - ($bits(tmc_t) + $bits(wspawn_t) + $bits(barrier_t) + $bits(split_t));

    typedef struct packed {
        logic [CTL_PAD_BITS-1:0] pad;
        tmc_t                    tmc;
        wspawn_t                 wspawn;
        barrier_t                barrier;
        split_t                  split;
    } warp_ctl_t;

    typedef union packed {
        warp_ctl_t                    ctl;
        logic [NUM_THREADS-1:0][31:0] texel;
    } gpu_rsp_data_u;

    typedef struct packed {
        logic [NW_BITS-1:0]     wid;
        logic [NUM_THREADS-1:0] tmask;
        logic [31:0]            pc;
        logic                   is_tex;
        gpu_rsp_data_u          data;
    } gpu_commit_t;

    typedef struct packed {
        logic [NW_BITS-1:0]           wid;
        logic [NUM_THREADS-1:0]       tmask;
        logic [31:0]                  pc;
        logic [NUM_THREADS-1:0][31:0] u;
        logic [NUM_THREADS-1:0][31:0] v;
    } tex_req_t;

    typedef struct packed {
        logic [NW_BITS-1:0]           wid;
        logic [NUM_THREADS-1:0]       tmask;
        logic [31:0]                  pc;
        logic [NUM_THREADS-1:0][31:0] texel;
    } tex_rsp_t;

    typedef struct packed {
        logic                     we;
        logic [TEX_ADDR_BITS-1:0] addr;
        logic [31:0]              wdata;
    } mem_req_t;

endpackage

/* hw/warp_ctl_decode.sv */
`timescale 1ns/1ps

module warp_ctl_decode import gpu_pkg::*; (
    input  gpu_req_t  req,
    output warp_ctl_t ctl
);

    logic [NUM_THREADS-1:0] then_mask;
    logic [NUM_THREADS-1:0] else_mask;

    // branch outcome per active lane
    always_comb begin
        for (int i = 0; i < NUM_THREADS; i++) begin
            then_mask[i] = req.tmask[i] & req.rs1_data[i][0];
            else_mask[i] = req.tmask[i] & ~req.rs1_data[i][0];
        end
    end

    always_comb begin
        ctl = '0;

        // thread count in rs1 lane0
        ctl.tmc.valid = (req.op_type == GPU_TMC);
        for (int i = 0; i < NUM_THREADS; i++) begin
            ctl.tmc.tmask[i] = (32'(i) < req.rs1_data[0]);
        end

        // warp count in rs1 lane0, start pc in rs2 lane0
        ctl.wspawn.valid = (req.op_type == GPU_WSPAWN);
        for (int i = 0; i < NUM_WARPS; i++) begin
            ctl.wspawn.wmask[i] = (32'(i) < req.rs1_data[0]);
        end
        ctl.wspawn.pc = req.rs2_data[0];

        ctl.split.valid     = (req.op_type == GPU_SPLIT);
        ctl.split.diverged  = (|then_mask) && (|else_mask);
        ctl.split.then_mask = then_mask;
        ctl.split.else_mask = else_mask;
        ctl.split.pc        = req.next_pc;

        ctl.barrier.valid   = (req.op_type == GPU_BAR);
        ctl.barrier.id      = req.rs1_data[0][NB_BITS-1:0];
        ctl.barrier.size_m1 = NW_BITS'(req.rs2_data[0] - 32'd1);
    end

endmodule

/* hw/tex_unit.sv */
`timescale 1ns/1ps

module tex_unit import gpu_pkg::*; #(
    parameter int UNIT_ID = 0
) (
    input  logic        clk,
    input  logic        arst_n,
    input  tex_req_t    req,
    input  logic        req_valid,
    output logic        req_ready,
    output tex_rsp_t    rsp,
    output logic        rsp_valid,
    input  logic        rsp_ready,
    output mem_req_t    mem_req,
    output logic        mem_valid,
    input  logic        mem_grant,
    input  logic [31:0] mem_rdata
);

    localparam int LANE_BITS = $clog2(NUM_THREADS);
    localparam int UNIT_BITS = TEX_ADDR_BITS - 8;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_RESPOND
    } state_e;

    state_e                       state_q;
    logic [LANE_BITS:0]           lane_q;
    logic                         rd_pend_q;
    logic [LANE_BITS-1:0]         rd_lane_q;
    tex_req_t                     req_q;
    logic [NUM_THREADS-1:0][31:0] texel_q;
    logic [LANE_BITS-1:0]         lane;
    logic                         lanes_done;
    logic                         lane_active;
    logic                         issued;

    assign lane        = lane_q[LANE_BITS-1:0];
    assign lanes_done  = lane_q[LANE_BITS];
    assign lane_active = req_q.tmask[lane];

    assign req_ready = (state_q == ST_IDLE);
    assign mem_valid = (state_q == ST_FETCH) && !lanes_done && lane_active;
    assign issued    = mem_valid && mem_grant;

    // point sample at word {unit, v[3:0], u[3:0]}
    assign mem_req.we    = 1'b0;
    assign mem_req.addr  = {UNIT_BITS'(UNIT_ID), req_q.v[lane][3:0], req_q.u[lane][3:0]};
    assign mem_req.wdata = '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= ST_IDLE;
            lane_q    <= '0;
            rd_pend_q <= 1'b0;
        end else begin
            rd_pend_q <= issued;
            case (state_q)
                ST_IDLE: begin
                    if (req_valid) begin
                        state_q <= ST_FETCH;
                        lane_q  <= '0;
                    end
                end
                ST_FETCH: begin
                    // inactive lanes are stepped over without a read
                    if (!lanes_done && (issued || !lane_active)) begin
                        lane_q <= lane_q + 1'b1;
                    end
                    // last read data lands before the response
                    if (lanes_done && !rd_pend_q) begin
                        state_q <= ST_RESPOND;
                    end
                end
                ST_RESPOND: begin
                    if (rsp_ready) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        rd_lane_q <= lane;
        if (req_valid && req_ready) begin
            req_q   <= req;
            texel_q <= '0;
        end else if (rd_pend_q) begin
            texel_q[rd_lane_q] <= mem_rdata;
        end
    end

    assign rsp_valid = (state_q == ST_RESPOND);
    assign rsp.wid   = req_q.wid;
    assign rsp.tmask = req_q.tmask;
    assign rsp.pc    = req_q.pc;
    assign rsp.texel = texel_q;

endmodule

/* hw/tex_mem_arbiter.sv */
`timescale 1ns/1ps

module tex_mem_arbiter import gpu_pkg::*; #(
    parameter int NUM_REQ = 3
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  mem_req_t [NUM_REQ-1:0] req,
    input  logic [NUM_REQ-1:0]     valid,
    output logic [NUM_REQ-1:0]     grant,
    output mem_req_t               mem_req,
    output logic                   mem_en,
    input  logic [31:0]            rdata_in,
    output logic [31:0]            rdata
);

    localparam int IDX_BITS = $clog2(NUM_REQ);

    logic [IDX_BITS-1:0] last_q;
    logic [IDX_BITS-1:0] win_idx;
    logic                win_valid;

    // search starts one past the last winner
    always_comb begin
        int idx;
        win_valid = 1'b0;
        win_idx   = last_q;
        for (int off = 1; off <= NUM_REQ; off++) begin
            idx = (int'(last_q) + off) % NUM_REQ;
            if (!win_valid && valid[idx]) begin
                win_valid = 1'b1;
                win_idx   = IDX_BITS'(idx);
            end
        end
    end

    always_comb begin
        grant          = '0;
        grant[win_idx] = win_valid;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_q <= IDX_BITS'(NUM_REQ - 1);
        end else if (win_valid) begin
            last_q <= win_idx;
        end
    end

    assign mem_req = req[win_idx];
    assign mem_en  = win_valid;

    // return bus belongs to the winner of the previous cycle
    assign rdata = rdata_in;

endmodule

/* hw/tex_mem.sv */
`timescale 1ns/1ps

module tex_mem import gpu_pkg::*; #(
    parameter int ADDR_BITS = TEX_ADDR_BITS
) (
    input  logic        clk,
    input  logic        en,
    input  mem_req_t    req,
    output logic [31:0] rdata
);

    logic [31:0] mem [2**ADDR_BITS];

    always_ff @(posedge clk) begin
        if (en) begin
            if (req.we) begin
                mem[req.addr[ADDR_BITS-1:0]] <= req.wdata;
            end else begin
                rdata <= mem[req.addr[ADDR_BITS-1:0]];
            end
        end
    end

endmodule

/* hw/gpu_unit.sv */
`timescale 1ns/1ps

module gpu_unit import gpu_pkg::*; #(
    parameter int NUM_TEX       = gpu_pkg::NUM_TEX,
    parameter int TEX_ADDR_BITS = gpu_pkg::TEX_ADDR_BITS
) (
    input  logic               clk,
    input  logic               arst_n,
    input  gpu_req_t           req,
    input  logic               req_valid,
    output logic               req_ready,
    output gpu_commit_t        commit,
    output logic               commit_valid,
    input  logic               commit_ready,
    output warp_ctl_t          warp_ctl,
    output logic [NW_BITS-1:0] warp_ctl_wid,
    output logic               warp_ctl_valid,
    input  mem_req_t           upload,
    input  logic               upload_valid,
    output logic               upload_ready
);

    localparam int NUM_REQ  = NUM_TEX + 1;
    localparam int SEL_BITS = $clog2(NUM_TEX);

    warp_ctl_t              ctl_dec;
    logic                   is_tex;
    logic                   stall_out;
    logic                   any_tex_rsp;
    tex_req_t               tex_req;
    logic [NUM_TEX-1:0]     tex_req_valid;
    logic [NUM_TEX-1:0]     tex_req_ready;
    tex_rsp_t [NUM_TEX-1:0] tex_rsp;
    logic [NUM_TEX-1:0]     tex_rsp_valid;
    logic [NUM_TEX-1:0]     tex_rsp_ready;
    mem_req_t [NUM_TEX-1:0] tex_mem_req;
    logic [NUM_TEX-1:0]     tex_mem_valid;
    mem_req_t [NUM_REQ-1:0] arb_req;
    logic [NUM_REQ-1:0]     arb_valid;
    logic [NUM_REQ-1:0]     arb_grant;
    logic [31:0]            arb_rdata;
    mem_req_t               mem_req;
    logic                   mem_en;
    logic [31:0]            mem_rdata;
    logic [SEL_BITS-1:0]    rsp_sel;
    gpu_commit_t            commit_d;

    warp_ctl_decode u_decode (
        .req (req),
        .ctl (ctl_dec)
    );

    assign is_tex    = (req.op_type == GPU_TEX);
    assign stall_out = commit_valid && !commit_ready;

    assign tex_req.wid   = req.wid;
    assign tex_req.tmask = req.tmask;
    assign tex_req.pc    = req.pc;
    assign tex_req.u     = req.rs1_data;
    assign tex_req.v     = req.rs2_data;

    // requester 0 is the host upload port
    assign arb_req[0]   = upload;
    assign arb_valid[0] = upload_valid;
    assign upload_ready = arb_grant[0];

    for (genvar t = 0; t < NUM_TEX; t++) begin : g_tex
        assign tex_req_valid[t] = req_valid && is_tex && (int'(req.op_mod) == t);
        assign tex_rsp_ready[t] = !stall_out && (rsp_sel == SEL_BITS'(t));
        assign arb_req[t+1]     = tex_mem_req[t];
        assign arb_valid[t+1]   = tex_mem_valid[t];

        tex_unit #(
            .UNIT_ID (t)
        ) u_tex (
            .clk       (clk),
            .arst_n    (arst_n),
            .req       (tex_req),
            .req_valid (tex_req_valid[t]),
            .req_ready (tex_req_ready[t]),
            .rsp       (tex_rsp[t]),
            .rsp_valid (tex_rsp_valid[t]),
            .rsp_ready (tex_rsp_ready[t]),
            .mem_req   (tex_mem_req[t]),
            .mem_valid (tex_mem_valid[t]),
            .mem_grant (arb_grant[t+1]),
            .mem_rdata (arb_rdata)
        );
    end

    tex_mem_arbiter #(
        .NUM_REQ (NUM_REQ)
    ) u_arbiter (
        .clk      (clk),
        .arst_n   (arst_n),
        .req      (arb_req),
        .valid    (arb_valid),
        .grant    (arb_grant),
        .mem_req  (mem_req),
        .mem_en   (mem_en),
        .rdata_in (mem_rdata),
        .rdata    (arb_rdata)
    );

    tex_mem #(
        .ADDR_BITS (TEX_ADDR_BITS)
    ) u_mem (
        .clk   (clk),
        .en    (mem_en),
        .req   (mem_req),
        .rdata (mem_rdata)
    );

    // lowest unit with a response wins
    always_comb begin
        rsp_sel = '0;
        for (int t = NUM_TEX - 1; t >= 0; t--) begin
            if (tex_rsp_valid[t]) begin
                rsp_sel = SEL_BITS'(t);
            end
        end
    end

    assign any_tex_rsp = |tex_rsp_valid;

    // control ops wait behind a texture response or a stalled commit
    assign req_ready = is_tex ? tex_req_ready[req.op_mod] : (!any_tex_rsp && !stall_out);

    always_comb begin
        commit_d = '0;
        if (any_tex_rsp) begin
            commit_d.wid        = tex_rsp[rsp_sel].wid;
            commit_d.tmask      = tex_rsp[rsp_sel].tmask;
            commit_d.pc         = tex_rsp[rsp_sel].pc;
            commit_d.is_tex     = 1'b1;
            commit_d.data.texel = tex_rsp[rsp_sel].texel;
        end else begin
            commit_d.wid      = req.wid;
            commit_d.tmask    = req.tmask;
            commit_d.pc       = req.pc;
            commit_d.is_tex   = 1'b0;
            commit_d.data.ctl = ctl_dec;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            commit_valid <= 1'b0;
        end else if (!stall_out) begin
            commit_valid <= any_tex_rsp || (req_valid && !is_tex);
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_out) begin
            commit <= commit_d;
        end
    end

    assign warp_ctl       = commit.data.ctl;
    assign warp_ctl_wid   = commit.wid;
    assign warp_ctl_valid = commit_valid && commit_ready && !commit.is_tex;

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release on a falling edge away from the active edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

/* verification/gpu_unit_tb.sv */
`timescale 1ns/1ps

module gpu_unit_tb import gpu_pkg::*; ();

    localparam int NUM_ROWS  = 16;
    localparam int TIMEOUT   = 200;
    localparam int MEM_WORDS = 2 ** TEX_ADDR_BITS;

    typedef struct packed {
        gpu_req_t   req;
        logic [7:0] stall;
        logic       chain;
    } row_t;

    logic               clk;
    logic               arst_n;
    gpu_req_t           req;
    logic               req_valid;
    logic               req_ready;
    gpu_commit_t        commit;
    logic               commit_valid;
    logic               commit_ready;
    warp_ctl_t          warp_ctl;
    logic [NW_BITS-1:0] warp_ctl_wid;
    logic               warp_ctl_valid;
    mem_req_t           upload;
    logic               upload_valid;
    logic               upload_ready;

    row_t        rows       [NUM_ROWS];
    gpu_commit_t expected   [NUM_ROWS];
    logic        pending    [NUM_ROWS];
    int          accept_cyc [NUM_ROWS];
    int          row_errs   [NUM_ROWS];
    logic [31:0] model_mem  [MEM_WORDS];
    int          pending_count;
    int          err_count;
    int          rows_done;
    int          seed;
    int          cyc = 0;
    logic        timed_out;
    logic        held_valid;
    gpu_commit_t held_commit;

    tb_clock_gen #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (3)
    ) u_clock (
        .clk    (clk),
        .arst_n (arst_n)
    );

    gpu_unit #(
        .NUM_TEX       (NUM_TEX),
        .TEX_ADDR_BITS (TEX_ADDR_BITS)
    ) gpu_unit_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .req            (req),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .commit         (commit),
        .commit_valid   (commit_valid),
        .commit_ready   (commit_ready),
        .warp_ctl       (warp_ctl),
        .warp_ctl_wid   (warp_ctl_wid),
        .warp_ctl_valid (warp_ctl_valid),
        .upload         (upload),
        .upload_valid   (upload_valid),
        .upload_ready   (upload_ready)
    );

    always @(posedge clk) cyc <= cyc + 1;

    task automatic count_error(input int row);
        err_count++;
        if (row >= 0) begin
            row_errs[row]++;
        end
    endtask

    task automatic value_error(input int row, input string name,
                               input logic [31:0] got, input logic [31:0] exp);
        if (row >= 0) begin
            $display("** Error row %0d: %s got %h exp %h", row, name, got, exp);
        end else begin
            $display("** Error: %s got %h exp %h", name, got, exp);
        end
        count_error(row);
    endtask

    task automatic give_up(input string what);
        $display("timeout while waiting for %s after %0d cycles", what, TIMEOUT);
        timed_out = 1'b1;
        err_count++;
    endtask

    // each lane operand is the row word shifted down by a byte per lane
    task automatic add_row(input int idx, input gpu_op_e op, input logic unit,
                           input logic [NUM_THREADS-1:0] tmask, input logic [31:0] a,
                           input logic [31:0] b, input int stall, input logic chain);
        row_t r;
        r               = '0;
        r.req.op_type   = op;
        r.req.op_mod    = unit;
        r.req.wid       = NW_BITS'(idx % NUM_WARPS);
        r.req.tmask     = tmask;
        r.req.pc        = 32'h1000 + 32'(idx) * 32'h10;
        r.req.next_pc   = r.req.pc + 32'd4;
        for (int i = 0; i < NUM_THREADS; i++) begin
            r.req.rs1_data[i] = a >> (8 * i);
            r.req.rs2_data[i] = b >> (8 * i);
        end
        r.stall   = 8'(stall);
        r.chain   = chain;
        rows[idx] = r;
    endtask

    task automatic build_table;
        add_row(0, GPU_TMC, 1'b0, 4'hf, 32'd0, 32'd0, 0, 1'b0);
        add_row(1, GPU_TMC, 1'b0, 4'hf, 32'd1, 32'd0, 0, 1'b0);
        add_row(2, GPU_TMC, 1'b0, 4'hf, 32'd2, 32'd0, 0, 1'b0);
        add_row(3, GPU_TMC, 1'b0, 4'hf, 32'd3, 32'd0, 0, 1'b0);
        add_row(4, GPU_TMC, 1'b0, 4'hf, 32'd4, 32'd0, 0, 1'b0);
        add_row(5, GPU_WSPAWN, 1'b0, 4'hf, 32'd3, 32'h0000_8040, 0, 1'b0);
        add_row(6, GPU_SPLIT, 1'b0, 4'b1011, 32'h0100_0101, 32'd0, 0, 1'b0);
        add_row(7, GPU_SPLIT, 1'b0, 4'b0111, 32'h0001_0001, 32'd0, 0, 1'b0);
        add_row(8, GPU_BAR, 1'b0, 4'hf, 32'd6, 32'd3, 0, 1'b0);
        add_row(9, GPU_TEX, 1'b0, 4'b1101, 32'h3fa2_5107, 32'h0ce4_9b20, 0, 1'b0);
        add_row(10, GPU_TEX, 1'b1, 4'b1111, 32'h8e0d_6b14, 32'h47f3_2a99, 0, 1'b0);
        // two units in flight, then a control op behind them
        add_row(11, GPU_TEX, 1'b0, 4'b0111, 32'h1234_5678, 32'h9abc_def0, 0, 1'b1);
        add_row(12, GPU_TEX, 1'b1, 4'b1010, 32'h0f1e_2d3c, 32'h4b5a_6978, 0, 1'b1);
        add_row(13, GPU_TMC, 1'b0, 4'hf, 32'd2, 32'd0, 0, 1'b0);
        add_row(14, GPU_TEX, 1'b1, 4'b1111, 32'hc3d2_e1f0, 32'h8877_6655, 8, 1'b0);
        add_row(15, GPU_SPLIT, 1'b0, 4'b1111, 32'h0001_0001, 32'd0, 5, 1'b0);
    endtask

    function automatic logic [31:0] low_ones(input logic [31:0] count, input int width);
        if (count >= 32'(width)) begin
            return (32'd1 << width) - 32'd1;
        end
        return (32'd1 << count) - 32'd1;
    endfunction

    function automatic gpu_commit_t expect_commit(input row_t r);
        gpu_commit_t            c;
        warp_ctl_t              w;
        logic [NUM_THREADS-1:0] bits;
        int                     addr;
        c       = '0;
        w       = '0;
        c.wid   = r.req.wid;
        c.tmask = r.req.tmask;
        c.pc    = r.req.pc;
        for (int i = 0; i < NUM_THREADS; i++) begin
            bits[i] = r.req.rs1_data[i][0];
        end
        case (r.req.op_type)
            GPU_TMC: begin
                w.tmc.valid = 1'b1;
                w.tmc.tmask = NUM_THREADS'(low_ones(r.req.rs1_data[0], NUM_THREADS));
            end
            GPU_WSPAWN: begin
                w.wspawn.valid = 1'b1;
                w.wspawn.wmask = NUM_WARPS'(low_ones(r.req.rs1_data[0], NUM_WARPS));
                w.wspawn.pc    = r.req.rs2_data[0];
            end
            GPU_SPLIT: begin
                w.split.valid     = 1'b1;
                w.split.then_mask = r.req.tmask & bits;
                w.split.else_mask = r.req.tmask & ~bits;
                w.split.diverged  = (w.split.then_mask != 0) && (w.split.else_mask != 0);
                w.split.pc        = r.req.next_pc;
            end
            GPU_BAR: begin
                w.barrier.valid   = 1'b1;
                w.barrier.id      = r.req.rs1_data[0][NB_BITS-1:0];
                w.barrier.size_m1 = NW_BITS'(r.req.rs2_data[0] - 32'd1);
            end
            default: begin
                c.is_tex = 1'b1;
            end
        endcase
        if (c.is_tex) begin
            for (int i = 0; i < NUM_THREADS; i++) begin
                // word index is unit, then v, then u
                addr = int'(r.req.op_mod) * 256 + int'(r.req.rs2_data[i][3:0]) * 16
                     + int'(r.req.rs1_data[i][3:0]);
                c.data.texel[i] = r.req.tmask[i] ? model_mem[addr] : 32'd0;
            end
        end else begin
            c.data.ctl = w;
        end
        return c;
    endfunction

    function automatic int find_row(input logic [31:0] pc);
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].req.pc === pc) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic check_warp_ctl(input int row, input string name,
                                  input warp_ctl_t got, input warp_ctl_t exp);
        logic [3:0] got_v;
        logic [3:0] exp_v;
        got_v = {got.tmc.valid, got.wspawn.valid, got.barrier.valid, got.split.valid};
        exp_v = {exp.tmc.valid, exp.wspawn.valid, exp.barrier.valid, exp.split.valid};
        if (got_v !== exp_v)
            value_error(row, {name, ".valid"}, 32'(got_v), 32'(exp_v));
        if (exp.tmc.valid && got.tmc.tmask !== exp.tmc.tmask)
            value_error(row, {name, ".tmc.tmask"}, 32'(got.tmc.tmask), 32'(exp.tmc.tmask));
        if (exp.wspawn.valid) begin
            if (got.wspawn.wmask !== exp.wspawn.wmask)
                value_error(row, {name, ".wspawn.wmask"}, 32'(got.wspawn.wmask),
                            32'(exp.wspawn.wmask));
            if (got.wspawn.pc !== exp.wspawn.pc)
                value_error(row, {name, ".wspawn.pc"}, got.wspawn.pc, exp.wspawn.pc);
        end
        if (exp.barrier.valid) begin
            if (got.barrier.id !== exp.barrier.id)
                value_error(row, {name, ".barrier.id"}, 32'(got.barrier.id),
                            32'(exp.barrier.id));
            if (got.barrier.size_m1 !== exp.barrier.size_m1)
                value_error(row, {name, ".barrier.size_m1"}, 32'(got.barrier.size_m1),
                            32'(exp.barrier.size_m1));
        end
        if (exp.split.valid) begin
            if (got.split.then_mask !== exp.split.then_mask)
                value_error(row, {name, ".split.then_mask"}, 32'(got.split.then_mask),
                            32'(exp.split.then_mask));
            if (got.split.else_mask !== exp.split.else_mask)
                value_error(row, {name, ".split.else_mask"}, 32'(got.split.else_mask),
                            32'(exp.split.else_mask));
            if (got.split.diverged !== exp.split.diverged)
                value_error(row, {name, ".split.diverged"}, 32'(got.split.diverged),
                            32'(exp.split.diverged));
            if (got.split.pc !== exp.split.pc)
                value_error(row, {name, ".split.pc"}, got.split.pc, exp.split.pc);
        end
    endtask

    task automatic check_commit(input gpu_commit_t got);
        int      row;
        gpu_op_e op;
        row = find_row(got.pc);
        if (row < 0) begin
            $display("commit with unknown pc %h", got.pc);
            count_error(-1);
        end else if (!pending[row]) begin
            $display("row %0d committed a second time", row);
            count_error(row);
        end else begin
            pending[row] = 1'b0;
            pending_count--;
            if (got.wid !== expected[row].wid)
                value_error(row, "commit.wid", 32'(got.wid), 32'(expected[row].wid));
            if (got.tmask !== expected[row].tmask)
                value_error(row, "commit.tmask", 32'(got.tmask), 32'(expected[row].tmask));
            if (got.is_tex !== expected[row].is_tex)
                value_error(row, "commit.is_tex", 32'(got.is_tex), 32'(expected[row].is_tex));
            if (expected[row].is_tex) begin
                for (int i = 0; i < NUM_THREADS; i++) begin
                    if (got.data.texel[i] !== expected[row].data.texel[i])
                        value_error(row, $sformatf("commit.data.texel[%0d]", i),
                                    got.data.texel[i], expected[row].data.texel[i]);
                end
            end else begin
                check_warp_ctl(row, "commit.data.ctl", got.data.ctl, expected[row].data.ctl);
                if (rows[row].stall == 0 && cyc != accept_cyc[row] + 1) begin
                    $display("row %0d committed %0d cycles after acceptance instead of 1",
                             row, cyc - accept_cyc[row]);
                    count_error(row);
                end
            end
            rows_done++;
            op = rows[row].req.op_type;
            $display("row %0d %s pc %h: %s", row, op.name(), got.pc,
                     (row_errs[row] == 0) ? "ok" : "FAILED");
        end
    endtask

    // outputs are stable just after the falling edge
    task automatic sample_outputs;
        int   row;
        logic xfer;
        logic exp_ctl_valid;
        xfer          = commit_valid && commit_ready;
        row           = find_row(commit.pc);
        exp_ctl_valid = 1'b0;
        if (xfer === 1'b1 && row >= 0) begin
            exp_ctl_valid = !expected[row].is_tex;
        end
        if (held_valid && (commit_valid !== 1'b1 || commit !== held_commit)) begin
            $display("** Error: commit got %h exp %h", commit, held_commit);
            count_error(find_row(held_commit.pc));
        end
        if (warp_ctl_valid !== exp_ctl_valid)
            value_error(-1, "warp_ctl_valid", 32'(warp_ctl_valid), 32'(exp_ctl_valid));
        if (warp_ctl_valid === 1'b1 && row >= 0) begin
            check_warp_ctl(row, "warp_ctl", warp_ctl, expected[row].data.ctl);
            if (warp_ctl_wid !== expected[row].wid)
                value_error(row, "warp_ctl_wid", 32'(warp_ctl_wid), 32'(expected[row].wid));
        end
        if (xfer === 1'b1) begin
            check_commit(commit);
            held_valid = 1'b0;
        end else if (commit_valid === 1'b1) begin
            held_valid  = 1'b1;
            held_commit = commit;
        end else begin
            held_valid = 1'b0;
        end
    endtask

    initial begin
        held_valid = 1'b0;
        forever begin
            @(negedge clk);
            #2;
            sample_outputs();
        end
    end

    task automatic wait_for_reset;
        int n;
        n = 0;
        while (arst_n !== 1'b1 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (arst_n !== 1'b1) begin
            give_up("reset release");
        end else begin
            if (commit_valid !== 1'b0)
                value_error(-1, "commit_valid", 32'(commit_valid), 32'd0);
            if (warp_ctl_valid !== 1'b0)
                value_error(-1, "warp_ctl_valid", 32'(warp_ctl_valid), 32'd0);
            @(negedge clk);
        end
    endtask

    task automatic upload_memory;
        int n;
        for (int a = 0; a < MEM_WORDS && !timed_out; a++) begin
            model_mem[a]  = $random(seed);
            upload.we     = 1'b1;
            upload.addr   = TEX_ADDR_BITS'(a);
            upload.wdata  = model_mem[a];
            upload_valid  = 1'b1;
            n = 0;
            #1;
            while (upload_ready !== 1'b1 && n < TIMEOUT) begin
                @(negedge clk);
                #1;
                n++;
            end
            if (upload_ready !== 1'b1) begin
                give_up("upload grant");
            end
            @(negedge clk);
        end
        upload_valid = 1'b0;
    endtask

    task automatic issue_row(input int idx);
        int   n;
        logic taken;
        n         = 0;
        taken     = 1'b0;
        req       = rows[idx].req;
        req_valid = 1'b1;
        while (!taken && n < TIMEOUT) begin
            #1;
            if (req_ready === 1'b1) begin
                taken           = 1'b1;
                accept_cyc[idx] = cyc;
            end
            @(negedge clk);
            n++;
        end
        req_valid = 1'b0;
        if (!taken) begin
            give_up($sformatf("acceptance of row %0d", idx));
        end
    endtask

    task automatic hold_commit(input int cycles);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < TIMEOUT) begin
            #1;
            if (commit_valid === 1'b1) begin
                seen = 1'b1;
            end else begin
                @(negedge clk);
                n++;
            end
        end
        if (!seen) begin
            give_up("a commit to stall");
        end else begin
            repeat (cycles) @(negedge clk);
        end
        commit_ready = 1'b1;
    endtask

    task automatic wait_idle;
        int n;
        n = 0;
        while (pending_count != 0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (pending_count != 0) begin
            give_up($sformatf("%0d outstanding commits", pending_count));
        end
    endtask

    task automatic run_row(input int idx);
        expected[idx] = expect_commit(rows[idx]);
        pending[idx]  = 1'b1;
        pending_count++;
        if (rows[idx].stall != 0) begin
            commit_ready = 1'b0;
        end
        issue_row(idx);
        if (!timed_out && rows[idx].stall != 0) begin
            hold_commit(int'(rows[idx].stall));
        end
        if (!timed_out && !rows[idx].chain) begin
            wait_idle();
        end
    endtask

    initial begin
        req           = '0;
        req_valid     = 1'b0;
        commit_ready  = 1'b1;
        upload        = '0;
        upload_valid  = 1'b0;
        timed_out     = 1'b0;
        err_count     = 0;
        rows_done     = 0;
        pending_count = 0;
        seed          = 32'h9758;
        for (int i = 0; i < NUM_ROWS; i++) begin
            pending[i]    = 1'b0;
            row_errs[i]   = 0;
            accept_cyc[i] = 0;
        end
        build_table();
        wait_for_reset();
        if (!timed_out) begin
            upload_memory();
        end
        for (int i = 0; i < NUM_ROWS && !timed_out; i++) begin
            run_row(i);
        end
        $display("rows done %0d of %0d, errors %0d", rows_done, NUM_ROWS, err_count);
        if (err_count == 0 && !timed_out && rows_done == NUM_ROWS) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* all.f */
hw/gpu_pkg.sv
hw/warp_ctl_decode.sv
hw/tex_unit.sv
hw/tex_mem_arbiter.sv
hw/tex_mem.sv
hw/gpu_unit.sv
verification/tb_clock_gen.sv
verification/gpu_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the gpu_unit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal -j 0 \
    --top-module gpu_unit_tb \
    -f all.f \
    --Mdir obj_dir -o gpu_unit_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

./obj_dir/gpu_unit_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

if grep -q "sim failed" "$SIM_LOG"; then
    exit 1
fi
exit 0
